// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    //////////////////////////////
    // Access size
    //////////////////////////////

    // RISC-V funct3 encoding of loads and stores
    // 011, 110 and 111 are left out on purpose and count as illegal
    typedef enum logic [2:0] {
        MEM_BYTE              = 3'b000,  // lb / sb
        MEM_HALFWORD          = 3'b001,  // lh / sh
        MEM_WORD              = 3'b010,  // lw / sw
        MEM_BYTE_UNSIGNED     = 3'b100,  // lbu only
        MEM_HALFWORD_UNSIGNED = 3'b101   // lhu only
    } mem_size_e;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    localparam int DATA_W = 32;          // Load and store data
    localparam int ADDR_W = 32;          // Byte address as it leaves the ALU

    //////////////////////////////
    // Memory geometry
    //////////////////////////////

    // One RAM lane per byte of a word
    localparam int LANES = 4;

    // Byte position within a word
    localparam int OFFSET_W = 2;

    localparam int WORD_ADDR_W = 8;      // 256 words per lane

    // Total size, anything at or above this is rejected
    localparam int unsigned MEM_BYTES = LANES << WORD_ADDR_W;

endpackage

`default_nettype wire

// ==== hdl/store_align.sv ====
`default_nettype none

module store_align (
    input  wire mem_pkg::mem_size_e    size,
    input  wire                        write,
    input  wire [mem_pkg::ADDR_W-1:0]  addr,
    input  wire [mem_pkg::DATA_W-1:0]  wdata,
    output logic [mem_pkg::LANES-1:0]  lane_we,
    output logic [mem_pkg::DATA_W-1:0] lane_wdata,
    output logic                       err
);

    logic [mem_pkg::OFFSET_W-1:0] offset;
    logic [mem_pkg::LANES-1:0]    lane_sel;   // Lanes touched if the access is good
    logic                         misaligned;
    logic                         bad_size;
    logic                         out_of_range;

    assign offset = addr[mem_pkg::OFFSET_W-1:0];

    //////////////////////////////
    // Lane select and replication
    //////////////////////////////

    always_comb begin
        misaligned = 1'b0;
        bad_size   = 1'b0;
        lane_sel   = '0;
        lane_wdata = wdata;
        case (size)
            mem_pkg::MEM_BYTE, mem_pkg::MEM_BYTE_UNSIGNED: begin
                lane_sel   = 4'b0001 << offset;
                lane_wdata = {mem_pkg::LANES{wdata[7:0]}};          // Byte on every lane
                bad_size   = write && (size == mem_pkg::MEM_BYTE_UNSIGNED);
            end
            mem_pkg::MEM_HALFWORD, mem_pkg::MEM_HALFWORD_UNSIGNED: begin
                misaligned = offset[0];
                lane_sel   = offset[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {(mem_pkg::LANES / 2){wdata[15:0]}};   // Low half, twice
                bad_size   = write && (size == mem_pkg::MEM_HALFWORD_UNSIGNED);
            end
            mem_pkg::MEM_WORD: begin
                misaligned = |offset;
                lane_sel   = '1;
            end
            default: begin
                bad_size = 1'b1;                                    // 011, 110, 111
            end
        endcase
    end

    //////////////////////////////
    // Error and write enables
    //////////////////////////////

    // Only the low 1 KiB is backed by RAM
    assign out_of_range = (addr >= mem_pkg::MEM_BYTES);

    assign err = misaligned || bad_size || out_of_range;

    // A rejected store must not disturb any lane
    assign lane_we = (write && !err) ? lane_sel : '0;

endmodule

`default_nettype wire

// ==== hdl/lane_ram.sv ====
`default_nettype none

module lane_ram (
    input  wire                             CLK,
    input  wire                             en,
    input  wire [mem_pkg::WORD_ADDR_W-1:0]  word_addr,
    input  wire [mem_pkg::LANES-1:0]        lane_we,
    input  wire [mem_pkg::DATA_W-1:0]       lane_wdata,
    output wire [mem_pkg::DATA_W-1:0]       lane_rdata
);

    //////////////////////////////
    // Byte lanes
    //////////////////////////////

    // Each lane is its own single-port block RAM, all sharing address and enable
    for (genvar i = 0; i < mem_pkg::LANES; i++) begin : g_lane
        logic [7:0] mem [0:(mem_pkg::MEM_BYTES / mem_pkg::LANES)-1];
        logic [7:0] rdata_q;

        always_ff @(posedge CLK) begin
            if (en) begin
                if (lane_we[i]) begin
                    mem[word_addr] <= lane_wdata[8*i +: 8];
                end
                rdata_q <= mem[word_addr];   // Old contents, read-first
            end
        end

        // Held while en is low so a stalled read stays visible
        assign lane_rdata[8*i +: 8] = rdata_q;
    end

endmodule

`default_nettype wire

// ==== hdl/load_extend.sv ====
`default_nettype none

module load_extend (
    input  wire mem_pkg::mem_size_e      size,
    input  wire [mem_pkg::OFFSET_W-1:0]  offset,
    input  wire [mem_pkg::DATA_W-1:0]    lane_rdata,
    output logic [mem_pkg::DATA_W-1:0]   rdata
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    //////////////////////////////
    // Lane selection
    //////////////////////////////

    // Byte at any offset
    assign sel_byte = lane_rdata[8*offset +: 8];

    // Halfword from the upper or lower pair, offset[0] is already known to be zero
    assign sel_half = offset[1] ? lane_rdata[31:16] : lane_rdata[15:0];

    //////////////////////////////
    // Extension
    //////////////////////////////

    always_comb begin
        case (size)
            mem_pkg::MEM_BYTE: begin
                rdata = {{(mem_pkg::DATA_W - 8){sel_byte[7]}}, sel_byte};
            end
            mem_pkg::MEM_BYTE_UNSIGNED: begin
                rdata = {{(mem_pkg::DATA_W - 8){1'b0}}, sel_byte};
            end
            mem_pkg::MEM_HALFWORD: begin
                rdata = {{(mem_pkg::DATA_W - 16){sel_half[15]}}, sel_half};
            end
            mem_pkg::MEM_HALFWORD_UNSIGNED: begin
                rdata = {{(mem_pkg::DATA_W - 16){1'b0}}, sel_half};
            end
            mem_pkg::MEM_WORD: begin
                rdata = lane_rdata;                 // All four lanes as stored
            end
            default: begin
                rdata = '0;                         // Undefined size
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  wire                         CLK,
    input  wire                         rst_n,

    // Request
    input  wire                         req_valid,
    input  wire                         req_write,
    input  wire mem_pkg::mem_size_e     req_size,
    input  wire [mem_pkg::ADDR_W-1:0]   req_addr,
    input  wire [mem_pkg::DATA_W-1:0]   req_wdata,
    output logic                        req_ready,

    // Response
    output logic                        rsp_valid,
    output logic [mem_pkg::DATA_W-1:0]  rsp_rdata,
    output logic                        rsp_err,
    input  wire                         rsp_ready
);

    //////////////////////////////
    // Handshake
    //////////////////////////////

    logic advance;     // Whole pipeline moves on this edge
    logic accept;      // Request transfers on this edge

    // Output slot empty, or being drained this cycle
    assign advance   = !rsp_valid || rsp_ready;
    assign req_ready = advance;
    assign accept    = req_valid && advance;

    //////////////////////////////
    // Store alignment
    //////////////////////////////

    logic [mem_pkg::LANES-1:0]  align_we;
    logic [mem_pkg::DATA_W-1:0] align_wdata;
    logic                       align_err;

    store_align i_store_align (
        .size       (req_size),
        .write      (req_write),
        .addr       (req_addr),
        .wdata      (req_wdata),
        .lane_we    (align_we),
        .lane_wdata (align_wdata),
        .err        (align_err)
    );

    //////////////////////////////
    // Lane memory
    //////////////////////////////

    logic                            ram_en;
    logic [mem_pkg::LANES-1:0]       ram_we;
    logic [mem_pkg::WORD_ADDR_W-1:0] ram_word_addr;
    logic [mem_pkg::DATA_W-1:0]      ram_rdata;

    // Read only on acceptance, so a stalled read keeps its data at the RAM output
    assign ram_en = accept;
    assign ram_we = align_we & {mem_pkg::LANES{accept}};

    // Word index sits right above the byte offset
    assign ram_word_addr = req_addr[mem_pkg::OFFSET_W +: mem_pkg::WORD_ADDR_W];

    lane_ram i_lane_ram (
        .CLK        (CLK),
        .en         (ram_en),
        .word_addr  (ram_word_addr),
        .lane_we    (ram_we),
        .lane_wdata (align_wdata),
        .lane_rdata (ram_rdata)
    );

    //////////////////////////////
    // Slot one
    //////////////////////////////

    // Describes the access the RAM is serving right now
    logic                         s1_valid;
    logic                         s1_write;
    logic                         s1_err;
    mem_pkg::mem_size_e           s1_size;
    logic [mem_pkg::OFFSET_W-1:0] s1_offset;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= req_valid;    // Bubble when nothing is offered
        end
    end

    // Size and offset travel with the read, not taken from the live address
    always_ff @(posedge CLK) begin
        if (accept) begin
            s1_write  <= req_write;
            s1_err    <= align_err;
            s1_size   <= req_size;
            s1_offset <= req_addr[mem_pkg::OFFSET_W-1:0];
        end
    end

    //////////////////////////////
    // Load extension
    //////////////////////////////

    logic [mem_pkg::DATA_W-1:0] ext_rdata;
    logic                       s1_good_load;

    load_extend i_load_extend (
        .size       (s1_size),
        .offset     (s1_offset),
        .lane_rdata (ram_rdata),
        .rdata      (ext_rdata)
    );

    assign s1_good_load = s1_valid && !s1_write && !s1_err;

    //////////////////////////////
    // Output slot
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else if (advance) begin
            rsp_valid <= s1_valid;
            rsp_err   <= s1_valid && s1_err;
        end
    end

    // Stores and errors answer with zero data
    always_ff @(posedge CLK) begin
        if (advance) begin
            rsp_rdata <= s1_good_load ? ext_rdata : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verification/mem_stage_assert.sv ====
`default_nettype none

module mem_stage_assert (
    input wire                        CLK,
    input wire                        rst_n,
    input wire                        rsp_valid,
    input wire                        rsp_ready,
    input wire [mem_pkg::DATA_W-1:0]  rsp_rdata,
    input wire                        rsp_err
);

    //////////////////////////////
    // Reset
    //////////////////////////////

    // Synchronous reset empties the output slot
    a_reset_empty : assert property (@(posedge CLK) !rst_n |=> !rsp_valid)
        else $error("rsp_valid high after a reset edge");

    //////////////////////////////
    // Response channel
    //////////////////////////////

    a_stall_stable : assert property (@(posedge CLK) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err))
        else $error("response changed or dropped while stalled");

    a_err_zero : assert property (@(posedge CLK) disable iff (!rst_n)
        rsp_err |-> rsp_rdata == '0)   // Failed requests carry no data
        else $error("rsp_err high with nonzero rsp_rdata");

endmodule

bind mem_stage mem_stage_assert i_mem_stage_assert (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err)
);

`default_nettype wire

// ==== verification/mem_stage_tb.sv ====
`default_nettype none

module mem_stage_tb;

    logic                         CLK;
    logic                         rst_n;
    logic                         req_valid;
    logic                         req_write;
    mem_pkg::mem_size_e           req_size;
    logic [mem_pkg::ADDR_W-1:0]   req_addr;
    logic [mem_pkg::DATA_W-1:0]   req_wdata;
    logic                         req_ready;
    logic                         rsp_valid;
    logic [mem_pkg::DATA_W-1:0]   rsp_rdata;
    logic                         rsp_err;
    logic                         rsp_ready;

    logic [7:0]                 model_mem [0:1023];   // Byte-addressed reference memory
    logic [mem_pkg::DATA_W-1:0] exp_data [$];         // Expected responses, request order
    logic                       exp_err [$];

    string test_name;
    int    cycle;
    int    acc_cycle;       // Edge of the last accepted request
    int    rsp_cycle;       // Edge of the last response transfer
    int    rsp_count;
    int    errors;
    int    start_errors;
    int    checks;
    int    tests;
    bit    random_ready;    // rsp_ready toggles at random when set

    mem_stage i_dut (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .rsp_ready (rsp_ready)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #10 CLK = ~CLK;
        end
    end

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string what, input logic [mem_pkg::DATA_W-1:0] exp_val,
                              input logic [mem_pkg::DATA_W-1:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
        end
    endtask

    task automatic check_err(input string what, input logic exp_val, input logic act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp_val, act_val);
        end
    endtask

    task automatic check_count(input string what, input int exp_val, input int act_val);
        checks++;
        if (act_val != exp_val) begin
            errors++;
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp_val, act_val);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Little-endian byte memory, no lanes involved
    function automatic void model_access(input logic write, input mem_pkg::mem_size_e size,
                                         input logic [31:0] addr, input logic [31:0] wdata,
                                         output logic [31:0] data, output logic err);
        int unsigned nbytes;
        logic        legal;
        logic [31:0] raw;
        data = '0;
        raw  = '0;
        case (size)
            mem_pkg::MEM_BYTE, mem_pkg::MEM_BYTE_UNSIGNED:         nbytes = 1;
            mem_pkg::MEM_HALFWORD, mem_pkg::MEM_HALFWORD_UNSIGNED: nbytes = 2;
            mem_pkg::MEM_WORD:                                     nbytes = 4;
            default:                                               nbytes = 0;
        endcase
        // Stores have no unsigned forms
        legal = (nbytes != 0) && !(write && (size == mem_pkg::MEM_BYTE_UNSIGNED ||
                                             size == mem_pkg::MEM_HALFWORD_UNSIGNED));
        if (!legal || addr >= 32'd1024) begin
            err = 1'b1;
        end else begin
            err = (addr % nbytes) != 0;
        end
        if (err) begin
            return;
        end
        for (int i = 0; i < nbytes; i++) begin
            if (write) begin
                model_mem[addr + i] = wdata[8*i +: 8];
            end else begin
                raw[8*i +: 8] = model_mem[addr + i];
            end
        end
        if (!write) begin
            case (size)
                mem_pkg::MEM_BYTE:     data = {{24{raw[7]}}, raw[7:0]};
                mem_pkg::MEM_HALFWORD: data = {{16{raw[15]}}, raw[15:0]};
                default:               data = raw;      // Word and zero-extended forms
            endcase
        end
    endfunction

    //////////////////////////////
    // Drivers and monitor
    //////////////////////////////

    task automatic report_timeout(input string msg);
        $display("error in %s: %s", test_name, msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic set_rsp_ready();
        rsp_ready = random_ready ? (($urandom % 4) != 0) : 1'b1;
    endtask

    task automatic send_req(input logic write, input mem_pkg::mem_size_e size,
                            input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] data;
        logic        err;
        int          waited;
        waited = 0;
        @(negedge CLK);
        req_valid = 1'b1;
        req_write = write;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        set_rsp_ready();
        @(posedge CLK);
        while (!req_ready) begin           // Request held while stalled
            waited++;
            if (waited > 50) begin
                report_timeout("request not accepted within 50 cycles");
            end
            @(negedge CLK);
            set_rsp_ready();
            @(posedge CLK);
        end
        acc_cycle = cycle;
        model_access(write, size, addr, wdata, data, err);
        exp_data.push_back(data);
        exp_err.push_back(err);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge CLK);
            req_valid = 1'b0;
            set_rsp_ready();
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        @(negedge CLK);
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        while (exp_data.size() != 0) begin
            waited++;
            if (waited > 50) begin
                report_timeout("no response within 50 cycles");
            end
            @(negedge CLK);
        end
        repeat (3) @(negedge CLK);   // Room for a stray extra response
    endtask

    always @(posedge CLK) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            rsp_cycle = cycle;
            rsp_count++;
            if (exp_data.size() == 0) begin
                errors++;
                $display("error in %s: response with no request outstanding", test_name);
            end else begin
                check_data("rsp_rdata", exp_data.pop_front(), rsp_rdata);
                check_err("rsp_err", exp_err.pop_front(), rsp_err);
            end
        end
    end

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s finished with %0d errors", test_name, errors - start_errors);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_basic();
        begin_test("basic");
        @(negedge CLK);
        check_err("rsp_valid after reset", 1'b0, rsp_valid);
        check_err("req_ready after reset", 1'b1, req_ready);
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h100, 32'hDEAD_BEEF);
        drain_responses();
        send_req(1'b0, mem_pkg::MEM_WORD, 32'h100, '0);
        drain_responses();
        check_count("load latency", 2, rsp_cycle - acc_cycle);
        end_test();
    endtask

    task automatic test_merge();
        begin_test("merge");
        for (int off = 0; off < 4; off++) begin
            send_req(1'b1, mem_pkg::MEM_WORD, 32'h200, 32'h1122_3344);
            send_req(1'b1, mem_pkg::MEM_BYTE, 32'h200 + off, 32'hFFFF_FFA0 + off);
            send_req(1'b0, mem_pkg::MEM_WORD, 32'h200, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            send_req(1'b1, mem_pkg::MEM_WORD, 32'h204, 32'h5566_7788);
            send_req(1'b1, mem_pkg::MEM_HALFWORD, 32'h204 + off, 32'h1234_BEEF ^ off);
            send_req(1'b0, mem_pkg::MEM_WORD, 32'h204, '0);
        end
        drain_responses();
        end_test();
    endtask

    task automatic test_extend();
        begin_test("extend");
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h300, 32'h80FF_7F81);
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h304, 32'h7F80_FF01);
        for (int a = 32'h300; a < 32'h308; a++) begin
            send_req(1'b0, mem_pkg::MEM_BYTE, a, '0);
            send_req(1'b0, mem_pkg::MEM_BYTE_UNSIGNED, a, '0);
            if (a % 2 == 0) begin
                send_req(1'b0, mem_pkg::MEM_HALFWORD, a, '0);
                send_req(1'b0, mem_pkg::MEM_HALFWORD_UNSIGNED, a, '0);
            end
        end
        drain_responses();
        end_test();
    endtask

    task automatic test_errors();
        begin_test("errors");
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h310, 32'hCAFE_F00D);
        send_req(1'b1, mem_pkg::MEM_HALFWORD, 32'h311, 32'h0000_1111);
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h312, 32'h2222_2222);
        send_req(1'b0, mem_pkg::MEM_HALFWORD, 32'h313, '0);
        send_req(1'b0, mem_pkg::MEM_WORD, 32'h311, '0);
        send_req(1'b1, mem_pkg::MEM_BYTE_UNSIGNED, 32'h310, 32'h0000_0033);
        send_req(1'b1, mem_pkg::MEM_HALFWORD_UNSIGNED, 32'h310, 32'h0000_4444);
        send_req(1'b1, mem_pkg::mem_size_e'(3'b011), 32'h310, 32'h5555_5555);
        send_req(0, mem_pkg::mem_size_e'(3'b110), 32'h310, '0);
        send_req(0, mem_pkg::mem_size_e'(3'b111), 32'h310, '0);
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h400, 32'h6666_6666);
        send_req(1'b1, mem_pkg::MEM_WORD, 32'h710, 32'h7777_7777);   // Aliases word 0x310
        send_req(1'b0, mem_pkg::MEM_WORD, 32'hFFFF_FFFC, '0);
        send_req(1'b0, mem_pkg::MEM_WORD, 32'h310, '0);
        drain_responses();
        end_test();
    endtask

    task automatic test_stream();
        int          rsp0;
        logic        wr;
        logic [31:0] fill;
        begin_test("stream");
        for (int a = 0; a < 256; a += 4) begin
            fill = (a * 32'h0101_0101) ^ 32'hA5C3_0F96;   // Differs in every word
            send_req(1'b1, mem_pkg::MEM_WORD, a, fill);
        end
        drain_responses();
        rsp0 = rsp_count;
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++) begin
            if ($urandom % 4 == 0) begin
                idle_cycles($urandom % 3 + 1);
            end
            wr = ($urandom % 2) == 1;
            send_req(wr, random_size(), $urandom % 256, $urandom);
        end
        random_ready = 1'b0;
        drain_responses();
        check_count("responses received", 200, rsp_count - rsp0);
        end_test();
    endtask

    // Mostly legal codes, now and then an undefined one
    function automatic mem_pkg::mem_size_e random_size();
        int pick;
        pick = $urandom % 16;
        if (pick >= 14) begin
            random_size = (pick == 14) ? mem_pkg::mem_size_e'(3'b011)
                                       : mem_pkg::mem_size_e'(3'b111);
        end else begin
            case (pick % 5)
                0:       random_size = mem_pkg::MEM_BYTE;
                1:       random_size = mem_pkg::MEM_HALFWORD;
                2:       random_size = mem_pkg::MEM_WORD;
                3:       random_size = mem_pkg::MEM_BYTE_UNSIGNED;
                default: random_size = mem_pkg::MEM_HALFWORD_UNSIGNED;
            endcase
        end
    endfunction

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(75755));
        cycle        = 0;
        rsp_count    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        random_ready = 1'b0;
        test_name    = "reset";
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_size     = mem_pkg::MEM_WORD;
        req_addr     = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b1;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_basic();
        test_merge();
        test_extend();
        test_errors();
        test_stream();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/mem_pkg.sv
hdl/store_align.sv
hdl/lane_ram.sv
hdl/load_extend.sv
hdl/mem_stage.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # Memory stage RTL, package first
  - files:
      - hdl/mem_pkg.sv
      - hdl/store_align.sv
      - hdl/lane_ram.sv
      - hdl/load_extend.sv
      - hdl/mem_stage.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/mem_stage_assert.sv
      - verification/mem_stage_tb.sv
